// File: design/id_pkg.sv
/* Shared types and constants of the decode stage: register address, function code,
   source and instruction control flags, misconduct code, opcodes, scrub range */
package id_pkg;

    typedef logic [4:0] rf_add_t;   // Register-file address
    typedef logic [3:0] f_part_t;   // {instr[30], funct3}
    typedef logic [3:0] sctrl_t;    // Source-control flags
    typedef logic [5:0] ictrl_t;    // Instruction-control flags

    // Bit positions inside sctrl_t
    localparam int SCTRL_RFRP1 = 0;  // Read port 1 needed
    localparam int SCTRL_RFRP2 = 1;  // Read port 2 needed
    localparam int SCTRL_ZERO1 = 2;  // Source 1 is x0
    localparam int SCTRL_ZERO2 = 3;  // Source 2 is x0

    // Bit positions inside ictrl_t, an all-zero value is a bubble
    localparam int ICTRL_ALU    = 0;
    localparam int ICTRL_LOAD   = 1;
    localparam int ICTRL_STORE  = 2;
    localparam int ICTRL_BRANCH = 3;
    localparam int ICTRL_JUMP   = 4;
    localparam int ICTRL_WRD    = 5;  // Writes rd

    typedef enum logic [1:0] {
        IMISCON_FREE = 2'b00,   // No problem
        IMISCON_FERR = 2'b01,   // Fetch error
        IMISCON_ILLE = 2'b10    // Illegal instruction
    } imiscon_t;

    // RV32I major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // Register-file scrub address range, x0 is never scrubbed
    localparam rf_add_t SCRUB_FIRST = 5'd1;
    localparam rf_add_t SCRUB_LAST  = 5'd31;

endpackage

// File: design/aligned_if.sv
/* Aligned instruction channel between aligner, decoder and ID register */
`timescale 1ns/1ps

interface aligned_if;

    logic        valid;     // Instruction offered
    logic        ready;     // ID register can take it
    logic [31:0] instr;     // Reassembled 32-bit instruction
    logic        ferr;      // One of its halves came with a fetch error

    modport src (
        output valid, instr, ferr,
        input  ready
    );

    modport dst (
        input  valid, instr, ferr,
        output ready
    );

    // Decoder only watches the payload
    modport dec (
        input valid, ready, instr, ferr
    );

endinterface

// File: design/aligner.sv
/* Halfword aligner that rebuilds 32-bit instructions from fetch words,
   with valid/ready on the fetch side and on the aligned channel */
`timescale 1ns/1ps

module aligner (
    input  logic        s_clk_i,
    input  logic        arst_n_i,
    input  logic        flush_i,

    input  logic        fetch_valid_i,
    output logic        fetch_ready_o,
    input  logic [31:0] fetch_word_i,
    input  logic        fetch_half_i,   // Lower halfword is not part of the stream
    input  logic        fetch_err_i,

    aligned_if.src      out_o
);

    logic        held_q;      // Upper halfword of an earlier word waits in half_q
    logic [15:0] half_q;
    logic        herr_q;      // Fetch error tag of half_q
    logic        accept;
    logic        keep_upper;

    // A jump word brings a single halfword, so it never completes an instruction
    assign out_o.valid = fetch_valid_i & ~fetch_half_i & ~flush_i;

    // With a held halfword the instruction straddles, otherwise the word is whole
    assign out_o.instr = held_q ? {fetch_word_i[15:0], half_q} : fetch_word_i;
    assign out_o.ferr  = fetch_err_i | (held_q & herr_q);

    // Buffer always has room for the leftover, so only the consumer can stall
    assign fetch_ready_o = ~flush_i & (fetch_half_i | out_o.ready);
    assign accept        = fetch_valid_i & fetch_ready_o;

    // Upper half stays behind on a jump word or while straddling
    assign keep_upper = fetch_half_i | held_q;

    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            held_q <= 1'b0;
        end else if (flush_i) begin
            held_q <= 1'b0;        // Stream restarts after redirect
        end else if (accept && fetch_half_i) begin
            held_q <= 1'b1;
        end
    end

    always_ff @(posedge s_clk_i) begin
        if (accept && keep_upper) begin
            half_q <= fetch_word_i[31:16];
            herr_q <= fetch_err_i;
        end
    end

    // Offered instruction holds until the ID register takes it
    a_out_stable : assert property (
        @(posedge s_clk_i) disable iff (!arst_n_i || flush_i)
        (out_o.valid && !out_o.ready) |=>
            (out_o.valid && $stable(out_o.instr) && $stable(out_o.ferr))
    );

endmodule

// File: design/decoder.sv
/* Combinational RV32I decoder: register fields, immediate, function code,
   source and instruction control flags, misconduct code */
`timescale 1ns/1ps

module decoder (
    aligned_if.dec              in_i,

    output id_pkg::rf_add_t     rs1_o,
    output id_pkg::rf_add_t     rs2_o,
    output id_pkg::rf_add_t     rd_o,
    output logic [31:0]         imm_o,
    output id_pkg::f_part_t     f_o,
    output id_pkg::sctrl_t      sctrl_o,
    output id_pkg::ictrl_t      ictrl_o,
    output id_pkg::imiscon_t    imiscon_o
);

    logic [31:0]    ins;
    logic [6:0]     opc;
    logic           rfrp1;
    logic           rfrp2;
    logic           ille;
    id_pkg::ictrl_t dec_ictrl;

    assign ins = in_i.instr;
    assign opc = ins[6:0];

    assign rs1_o = ins[19:15];
    assign rs2_o = ins[24:20];
    assign rd_o  = ins[11:7];
    assign f_o   = {ins[30], ins[14:12]};

    always_comb begin
        imm_o     = '0;
        rfrp1     = 1'b0;
        rfrp2     = 1'b0;
        dec_ictrl = '0;
        ille      = 1'b0;
        case (opc)
            id_pkg::OPC_LUI, id_pkg::OPC_AUIPC: begin
                imm_o                        = {ins[31:12], 12'b0};   // U-type
                dec_ictrl[id_pkg::ICTRL_ALU] = 1'b1;
                dec_ictrl[id_pkg::ICTRL_WRD] = 1'b1;
            end
            id_pkg::OPC_JAL: begin
                imm_o = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
                dec_ictrl[id_pkg::ICTRL_JUMP] = 1'b1;
                dec_ictrl[id_pkg::ICTRL_WRD]  = 1'b1;
            end
            id_pkg::OPC_JALR: begin
                imm_o                         = {{20{ins[31]}}, ins[31:20]};
                rfrp1                         = 1'b1;
                dec_ictrl[id_pkg::ICTRL_JUMP] = 1'b1;
                dec_ictrl[id_pkg::ICTRL_WRD]  = 1'b1;
            end
            id_pkg::OPC_BRANCH: begin
                // B-type
                imm_o = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                rfrp1 = 1'b1;
                rfrp2 = 1'b1;
                dec_ictrl[id_pkg::ICTRL_BRANCH] = 1'b1;
            end
            id_pkg::OPC_LOAD: begin
                imm_o                         = {{20{ins[31]}}, ins[31:20]};
                rfrp1                         = 1'b1;
                dec_ictrl[id_pkg::ICTRL_LOAD] = 1'b1;
                dec_ictrl[id_pkg::ICTRL_WRD]  = 1'b1;
            end
            id_pkg::OPC_STORE: begin
                imm_o                          = {{20{ins[31]}}, ins[31:25], ins[11:7]};
                rfrp1                          = 1'b1;
                rfrp2                          = 1'b1;
                dec_ictrl[id_pkg::ICTRL_STORE] = 1'b1;
            end
            id_pkg::OPC_OPIMM: begin
                imm_o                        = {{20{ins[31]}}, ins[31:20]};
                rfrp1                        = 1'b1;
                dec_ictrl[id_pkg::ICTRL_ALU] = 1'b1;
                dec_ictrl[id_pkg::ICTRL_WRD] = 1'b1;
            end
            id_pkg::OPC_OP: begin
                rfrp1                        = 1'b1;   // R-type, no immediate
                rfrp2                        = 1'b1;
                dec_ictrl[id_pkg::ICTRL_ALU] = 1'b1;
                dec_ictrl[id_pkg::ICTRL_WRD] = 1'b1;
            end
            default: ille = 1'b1;
        endcase
        if (ins[1:0] != 2'b11) begin
            ille = 1'b1;       // Compressed encodings are not supported
        end
    end

    always_comb begin
        sctrl_o                      = '0;
        sctrl_o[id_pkg::SCTRL_RFRP1] = rfrp1;
        sctrl_o[id_pkg::SCTRL_RFRP2] = rfrp2;
        sctrl_o[id_pkg::SCTRL_ZERO1] = (ins[19:15] == 5'd0);
        sctrl_o[id_pkg::SCTRL_ZERO2] = (ins[24:20] == 5'd0);
    end

    // Fetch error wins, a bad instruction stays present through imiscon alone
    always_comb begin
        if (in_i.ferr) begin
            imiscon_o = id_pkg::IMISCON_FERR;
        end else if (ille) begin
            imiscon_o = id_pkg::IMISCON_ILLE;
        end else begin
            imiscon_o = id_pkg::IMISCON_FREE;
        end
        ictrl_o = (imiscon_o == id_pkg::IMISCON_FREE) ? dec_ictrl : '0;
    end

endmodule

// File: design/id_stage.sv
/* ID/OP pipeline register with stall, flush and bubble insertion,
   plus the rotating register-file scrub address for unused read ports */
`timescale 1ns/1ps

module id_stage (
    input  logic                s_clk_i,
    input  logic                arst_n_i,
    input  logic                flush_i,
    input  logic                scrub_en_i,

    aligned_if.dst              in_i,

    input  id_pkg::rf_add_t     rs1_i,
    input  id_pkg::rf_add_t     rs2_i,
    input  id_pkg::rf_add_t     rd_i,
    input  logic [31:0]         imm_i,
    input  id_pkg::f_part_t     f_i,
    input  id_pkg::sctrl_t      sctrl_i,
    input  id_pkg::ictrl_t      ictrl_i,
    input  id_pkg::imiscon_t    imiscon_i,

    input  logic                op_ready_i,
    output logic                op_valid_o,
    output id_pkg::rf_add_t     op_rs1_o,
    output id_pkg::rf_add_t     op_rs2_o,
    output id_pkg::rf_add_t     op_rd_o,
    output logic [31:0]         op_imm_o,
    output id_pkg::f_part_t     op_f_o,
    output id_pkg::sctrl_t      op_sctrl_o,
    output id_pkg::ictrl_t      op_ictrl_o,
    output id_pkg::imiscon_t    op_imiscon_o
);

    logic            accept;
    logic            scrub1;      // Port 1 carries the scrub address
    logic            scrub2;
    id_pkg::rf_add_t scrub_q;

    // Slot holds an instruction if any control flag or misconduct is set
    assign op_valid_o = (op_ictrl_o != '0) | (op_imiscon_o != id_pkg::IMISCON_FREE);

    assign in_i.ready = ~op_valid_o | op_ready_i;
    assign accept     = in_i.valid & in_i.ready & ~flush_i;

    // A port is free when not read or when it reads x0
    assign scrub1 = scrub_en_i &
                    (~sctrl_i[id_pkg::SCTRL_RFRP1] | sctrl_i[id_pkg::SCTRL_ZERO1]);
    assign scrub2 = scrub_en_i &
                    (~sctrl_i[id_pkg::SCTRL_RFRP2] | sctrl_i[id_pkg::SCTRL_ZERO2]);

    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            op_ictrl_o   <= '0;
            op_imiscon_o <= id_pkg::IMISCON_FREE;
        end else if (accept) begin
            op_ictrl_o   <= ictrl_i;
            op_imiscon_o <= imiscon_i;
        end else if (flush_i || in_i.ready) begin
            op_ictrl_o   <= '0;                     // Bubble
            op_imiscon_o <= id_pkg::IMISCON_FREE;
        end
    end

    always_ff @(posedge s_clk_i) begin
        if (accept) begin
            op_rs1_o   <= scrub1 ? scrub_q : rs1_i;
            op_rs2_o   <= scrub2 ? scrub_q : rs2_i;
            op_rd_o    <= rd_i;
            op_imm_o   <= imm_i;
            op_f_o     <= f_i;
            op_sctrl_o <= sctrl_i;
        end
    end

    // Advances once per instruction that used it, on one port or both
    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            scrub_q <= id_pkg::SCRUB_FIRST;
        end else if (accept && (scrub1 || scrub2)) begin
            if (scrub_q == id_pkg::SCRUB_LAST) begin
                scrub_q <= id_pkg::SCRUB_FIRST;
            end else begin
                scrub_q <= scrub_q + 5'd1;
            end
        end
    end

    a_scrub_nonzero : assert property (
        @(posedge s_clk_i) disable iff (!arst_n_i) scrub_q != 5'd0
    );

    a_flush_empty : assert property (
        @(posedge s_clk_i) disable iff (!arst_n_i) flush_i |=> !op_valid_o
    );

    // A full register waiting on the OP side is not overwritten
    a_no_overrun : assert property (
        @(posedge s_clk_i) disable iff (!arst_n_i)
        (op_valid_o && !op_ready_i && !flush_i) |=>
            (op_valid_o && $stable(op_ictrl_o) && $stable(op_imiscon_o) &&
             $stable(op_rs1_o) && $stable(op_rs2_o) && $stable(op_imm_o))
    );

endmodule

// File: design/decode_top.sv
/* Decode stage top: aligner, decoder and ID/OP register */
`timescale 1ns/1ps

module decode_top (
    input  logic                s_clk_i,
    input  logic                arst_n_i,
    input  logic                flush_i,        // One-cycle pulse from a later stage
    input  logic                scrub_en_i,

    input  logic                fetch_valid_i,
    output logic                fetch_ready_o,
    input  logic [31:0]         fetch_word_i,
    input  logic                fetch_half_i,
    input  logic                fetch_err_i,

    input  logic                op_ready_i,
    output logic                op_valid_o,
    output id_pkg::rf_add_t     op_rs1_o,
    output id_pkg::rf_add_t     op_rs2_o,
    output id_pkg::rf_add_t     op_rd_o,
    output logic [31:0]         op_imm_o,
    output id_pkg::f_part_t     op_f_o,
    output id_pkg::sctrl_t      op_sctrl_o,
    output id_pkg::ictrl_t      op_ictrl_o,
    output id_pkg::imiscon_t    op_imiscon_o
);

    aligned_if al_if ();

    id_pkg::rf_add_t  dec_rs1;
    id_pkg::rf_add_t  dec_rs2;
    id_pkg::rf_add_t  dec_rd;
    logic [31:0]      dec_imm;
    id_pkg::f_part_t  dec_f;
    id_pkg::sctrl_t   dec_sctrl;
    id_pkg::ictrl_t   dec_ictrl;
    id_pkg::imiscon_t dec_imiscon;

    aligner m_aligner (
        .s_clk_i(s_clk_i),
        .arst_n_i(arst_n_i),
        .flush_i(flush_i),
        .fetch_valid_i(fetch_valid_i),
        .fetch_ready_o(fetch_ready_o),
        .fetch_word_i(fetch_word_i),
        .fetch_half_i(fetch_half_i),
        .fetch_err_i(fetch_err_i),
        .out_o(al_if.src)
    );

    decoder m_decoder (
        .in_i(al_if.dec),
        .rs1_o(dec_rs1),
        .rs2_o(dec_rs2),
        .rd_o(dec_rd),
        .imm_o(dec_imm),
        .f_o(dec_f),
        .sctrl_o(dec_sctrl),
        .ictrl_o(dec_ictrl),
        .imiscon_o(dec_imiscon)
    );

    id_stage m_id_stage (
        .s_clk_i(s_clk_i),
        .arst_n_i(arst_n_i),
        .flush_i(flush_i),
        .scrub_en_i(scrub_en_i),
        .in_i(al_if.dst),
        .rs1_i(dec_rs1),
        .rs2_i(dec_rs2),
        .rd_i(dec_rd),
        .imm_i(dec_imm),
        .f_i(dec_f),
        .sctrl_i(dec_sctrl),
        .ictrl_i(dec_ictrl),
        .imiscon_i(dec_imiscon),
        .op_ready_i(op_ready_i),
        .op_valid_o(op_valid_o),
        .op_rs1_o(op_rs1_o),
        .op_rs2_o(op_rs2_o),
        .op_rd_o(op_rd_o),
        .op_imm_o(op_imm_o),
        .op_f_o(op_f_o),
        .op_sctrl_o(op_sctrl_o),
        .op_ictrl_o(op_ictrl_o),
        .op_imiscon_o(op_imiscon_o)
    );

endmodule

// File: dv/decode_model.svh
/* Reference model of the decode stage: halfword queue, RV32I field decode, scrub counter */
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

typedef struct packed {
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm;
    logic [3:0]  f;
    logic [3:0]  sctrl;
    logic [5:0]  ictrl;
    logic [1:0]  imiscon;
} dec_fields_t;

logic [16:0] half_q[$];    // {fetch error tag, halfword} in stream order
logic [4:0]  scrub_ref;

function automatic void push_fetch_word(input logic [31:0] word, input logic half,
                                        input logic err);
    if (half) begin
        half_q.delete();   // Redirect drops the old leftover
    end else begin
        half_q.push_back({err, word[15:0]});
    end
    half_q.push_back({err, word[31:16]});
endfunction

function automatic void pop_instruction(output logic [31:0] instr, output logic ferr);
    logic [16:0] lo;
    logic [16:0] hi;
    lo    = half_q.pop_front();
    hi    = half_q.pop_front();
    instr = {hi[15:0], lo[15:0]};
    ferr  = lo[16] | hi[16];
endfunction

function automatic dec_fields_t decode_ref(input logic [31:0] i, input logic ferr);
    dec_fields_t d;
    logic        r1;
    logic        r2;
    logic        legal;
    logic [5:0]  ic;
    d     = '0;
    r1    = 1'b0;
    r2    = 1'b0;
    legal = 1'b1;
    ic    = '0;
    d.rs1 = i[19:15];
    d.rs2 = i[24:20];
    d.rd  = i[11:7];
    d.f   = {i[30], i[14:12]};
    case (i[6:0])
        7'b0110111, 7'b0010111: begin
            d.imm = {i[31:12], 12'h000};
            ic    = 6'b100001;                  // WRD, ALU
        end
        7'b1101111: begin
            d.imm = {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
            ic    = 6'b110000;                  // WRD, JUMP
        end
        7'b1100111: begin
            d.imm = {{21{i[31]}}, i[30:20]};
            r1    = 1'b1;
            ic    = 6'b110000;
        end
        7'b1100011: begin
            d.imm = {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
            r1    = 1'b1;
            r2    = 1'b1;
            ic    = 6'b001000;                  // BRANCH
        end
        7'b0000011: begin
            d.imm = {{21{i[31]}}, i[30:20]};
            r1    = 1'b1;
            ic    = 6'b100010;                  // WRD, LOAD
        end
        7'b0100011: begin
            d.imm = {{21{i[31]}}, i[30:25], i[11:7]};
            r1    = 1'b1;
            r2    = 1'b1;
            ic    = 6'b000100;                  // STORE
        end
        7'b0010011: begin
            d.imm = {{21{i[31]}}, i[30:20]};
            r1    = 1'b1;
            ic    = 6'b100001;
        end
        7'b0110011: begin
            r1 = 1'b1;
            r2 = 1'b1;
            ic = 6'b100001;
        end
        default: legal = 1'b0;
    endcase
    if (i[1:0] != 2'b11) legal = 1'b0;
    d.sctrl   = {i[24:20] == 5'd0, i[19:15] == 5'd0, r2, r1};
    d.imiscon = ferr ? 2'b01 : (legal ? 2'b00 : 2'b10);
    d.ictrl   = (d.imiscon == 2'b00) ? ic : 6'b000000;
    return d;
endfunction

// Unused ports take the scrub address, which moves on once per user
function automatic dec_fields_t with_scrub(input dec_fields_t d, input logic en);
    logic use1;
    logic use2;
    use1 = en & (~d.sctrl[0] | d.sctrl[2]);
    use2 = en & (~d.sctrl[1] | d.sctrl[3]);
    if (use1) d.rs1 = scrub_ref;
    if (use2) d.rs2 = scrub_ref;
    if (use1 || use2) scrub_ref = (scrub_ref == 5'd31) ? 5'd1 : scrub_ref + 5'd1;
    return d;
endfunction

`endif

// File: dv/tb_decode.sv
/* Testbench for the decode stage: random fetch stream, reference model scoreboard,
   back-pressure, flush and scrub checks */
`timescale 1ns/1ps

module tb_decode;

    `include "decode_model.svh"

    localparam int TEST_CYCLES = 4000;
    localparam int CYCLE_LIMIT = 16 + TEST_CYCLES + 1000;   // Reset, test, drain margin

    logic             s_clk_i;
    logic             arst_n_i;
    logic             flush_i;
    logic             scrub_en_i;
    logic             fetch_valid_i;
    logic             fetch_ready_o;
    logic [31:0]      fetch_word_i;
    logic             fetch_half_i;
    logic             fetch_err_i;
    logic             op_ready_i;
    logic             op_valid_o;
    id_pkg::rf_add_t  op_rs1_o;
    id_pkg::rf_add_t  op_rs2_o;
    id_pkg::rf_add_t  op_rd_o;
    logic [31:0]      op_imm_o;
    id_pkg::f_part_t  op_f_o;
    id_pkg::sctrl_t   op_sctrl_o;
    id_pkg::ictrl_t   op_ictrl_o;
    id_pkg::imiscon_t op_imiscon_o;

    integer      seed = 32'hcf2b;
    int          cycle_cnt = 0;
    int          stim_cycle = 0;
    int          model_cnt = 0;
    int          xfer_cnt = 0;
    logic        run_stim = 1'b0;
    logic        word_taken = 1'b0;   // Fetch word accepted at the coming edge
    logic        hold_prev = 1'b0;
    logic        flush_prev = 1'b0;
    dec_fields_t exp_q[$];
    logic [15:0] gen_q[$];            // Halfwords still to be fetched
    logic [6:0]  opc_tab[9] = '{7'b0110111, 7'b0010111, 7'b1101111, 7'b1100111,
                                7'b1100011, 7'b0000011, 7'b0100011, 7'b0010011,
                                7'b0110011};

    decode_top i_dut (.*);

    initial begin
        s_clk_i = 1'b0;
        forever #5 s_clk_i = ~s_clk_i;
    end

    task automatic stop_on_error();
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("error: %s = 0x%h, expected 0x%h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic compare_outputs(input dec_fields_t e);
        check_value("op_rs1_o", op_rs1_o, e.rs1);
        check_value("op_rs2_o", op_rs2_o, e.rs2);
        check_value("op_rd_o", op_rd_o, e.rd);
        check_value("op_imm_o", op_imm_o, e.imm);
        check_value("op_f_o", op_f_o, e.f);
        check_value("op_sctrl_o", op_sctrl_o, e.sctrl);
        check_value("op_ictrl_o", op_ictrl_o, e.ictrl);
        check_value("op_imiscon_o", op_imiscon_o, e.imiscon);
    endtask

    function automatic logic [31:0] rand_instr();
        logic [31:0] r;
        logic [31:0] s;
        logic [6:0]  opc;
        r = $random(seed);
        s = $random(seed);
        if (s[7:4] == 4'd0) begin
            opc = s[13] ? 7'b0001011 : {s[12:8], 2'b00};   // Illegal opcode
        end else begin
            opc = opc_tab[s[11:8] % 9];
        end
        return {r[31:7], opc};
    endfunction

    task automatic next_word();
        logic [31:0] r;
        logic [31:0] ins;
        r = $random(seed);
        fetch_err_i <= (r[7:4] == 4'd0);
        if (r[3:0] == 4'd0) begin
            gen_q.delete();                  // Jump into the middle of a word
            ins = rand_instr();
            fetch_word_i <= {ins[15:0], r[31:16]};
            fetch_half_i <= 1'b1;
            gen_q.push_back(ins[31:16]);
        end else begin
            while (gen_q.size() < 2) begin
                ins = rand_instr();
                gen_q.push_back(ins[15:0]);
                gen_q.push_back(ins[31:16]);
            end
            fetch_word_i <= {gen_q[1], gen_q[0]};
            fetch_half_i <= 1'b0;
            void'(gen_q.pop_front());
            void'(gen_q.pop_front());
        end
    endtask

    // Stimulus on the rising edge
    always @(posedge s_clk_i) begin
        if (run_stim) begin
            op_ready_i <= (($random(seed) & 3) != 0);
            scrub_en_i <= ((stim_cycle / 500) % 2) == 1;
            flush_i    <= 1'b0;
            if (!flush_i && (($random(seed) & 63) == 0)) begin
                flush_i       <= 1'b1;
                fetch_valid_i <= 1'b0;
                gen_q.delete();
            end else if (!fetch_valid_i || word_taken) begin
                if (($random(seed) & 7) != 0) begin
                    fetch_valid_i <= 1'b1;
                    next_word();
                end else begin
                    fetch_valid_i <= 1'b0;
                end
            end
            stim_cycle++;
        end else if (arst_n_i) begin
            op_ready_i <= 1'b1;              // Drain
            flush_i    <= 1'b0;
            if (word_taken) fetch_valid_i <= 1'b0;
        end
    end

    // Model and checks at the falling edge, where all signals are settled
    always @(negedge s_clk_i) begin
        logic [31:0] ins;
        logic        ferr;
        if (arst_n_i) begin
            if (flush_prev) begin
                assert (!op_valid_o) else begin
                    $display("OP side still valid in the cycle after a flush");
                    stop_on_error();
                end
            end
            // A stalled instruction stays put, its fields are held to the model below
            if (hold_prev) begin
                assert (op_valid_o) else begin
                    $display("stalled instruction left the OP side without a transfer");
                    stop_on_error();
                end
            end
            if (op_valid_o) begin
                assert (exp_q.size() != 0) else begin
                    $display("OP side valid with no instruction expected");
                    stop_on_error();
                end
                compare_outputs(exp_q[0]);
            end else begin
                assert (exp_q.size() == 0) else begin
                    $display("expected instruction missing on the OP side");
                    stop_on_error();
                end
            end
            if (op_valid_o && op_ready_i) begin
                void'(exp_q.pop_front());
                xfer_cnt++;
            end
            word_taken = fetch_valid_i && fetch_ready_o;
            if (flush_i) begin
                model_cnt -= exp_q.size();   // Flushed instruction never reaches the OP side
                exp_q.delete();
                half_q.delete();
            end else if (word_taken) begin
                push_fetch_word(fetch_word_i, fetch_half_i, fetch_err_i);
                if (!fetch_half_i) begin
                    pop_instruction(ins, ferr);
                    exp_q.push_back(with_scrub(decode_ref(ins, ferr), scrub_en_i));
                    model_cnt++;
                end
            end
            hold_prev  = op_valid_o && !op_ready_i && !flush_i;
            flush_prev = flush_i;
        end
    end

    always @(posedge s_clk_i) begin
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            stop_on_error();
        end
    end

    initial begin
        arst_n_i      = 1'b0;
        flush_i       = 1'b0;
        scrub_en_i    = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_word_i  = '0;
        fetch_half_i  = 1'b0;
        fetch_err_i   = 1'b0;
        op_ready_i    = 1'b0;
        scrub_ref     = 5'd1;
        repeat (16) @(posedge s_clk_i);
        arst_n_i <= 1'b1;
        @(negedge s_clk_i);
        run_stim = 1'b1;
        while (stim_cycle < TEST_CYCLES) @(negedge s_clk_i);
        run_stim = 1'b0;
        while (exp_q.size() != 0 || fetch_valid_i) @(posedge s_clk_i);
        @(posedge s_clk_i);
        if (xfer_cnt != model_cnt || exp_q.size() != 0) begin
            $display("transfer count %0d differs from model count %0d", xfer_cnt, model_cnt);
            stop_on_error();
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

// File: tb.f
+incdir+dv
design/id_pkg.sv
design/aligned_if.sv
design/aligner.sv
design/decoder.sv
design/id_stage.sv
design/decode_top.sv
dv/tb_decode.sv

// File: Makefile
.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module tb_decode

sim:
	verilator --binary --timing --assert -f tb.f --top-module tb_decode -Mdir obj_dir
	./obj_dir/Vtb_decode | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log
